//--- weightStream.f
+incdir+hdl
hdl/weightStreamPkg.sv
hdl/cfgIf.sv
hdl/memStream.sv
hdl/dotAccumulator.sv
hdl/weightStreamTop.sv
sim/weightStream_asserts.sv
sim/weightStreamTb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert --timing -Wno-fatal -j 0
TOP      := weightStreamTb
FILELIST := weightStream.f
LOG      := sim.log
RUNARGS  := +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNARGS) > $(LOG) 2>&1 || echo "TB FAILED" >> $(LOG)
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- sim/weightStreamTb.sv
// Seed 34 fixes the run; host writes in the last test avoid the next four stream addresses
`timescale 1ns/100ps
`include "weightStream_consts.svh"

module weightStreamTb;

	localparam int DEPTH = `WS_DEPTH;
	localparam int FOLD = `WS_FOLD;
	localparam int TIMEOUT = 2000;

	// DUT pins with known start values on the inputs
	logic clk = 1'b0;
	logic rst = 1'b1;
	logic cfgCe = 1'b0;
	logic cfgWe = 1'b0;
	logic [31:0] cfgAddr = '0;
	logic [`WS_WIDTH-1:0] cfgWdata = '0;
	logic cfgRack;
	logic [`WS_WIDTH-1:0] cfgRdata;
	logic actVld = 1'b0;
	logic actRdy;
	logic [`WS_WIDTH-1:0] actData = '0;
	logic resVld;
	logic resRdy = 1'b1;
	logic [`WS_ACC_BITS-1:0] resData;

	// Reference model state
	logic [`WS_WIDTH-1:0] shadow [DEPTH];
	weightStreamPkg::acc_t expQ [$];
	int beatCount = 0;
	int groupSum = 0;
	int resultsSeen = 0;
	int checks = 0;
	int errors = 0;
	// Set once any wait runs out of cycles
	logic timedOut = 1'b0;

	// Stimulus knobs set by the main sequence on clock edges
	int actRequested = 0;
	int actSent = 0;
	int gapPct = 0;
	// 0 always ready, 1 random, 2 held low
	int rdyMode = 0;

	weightStreamTop weightStreamTop_inst (
		.clk(clk), .rst(rst),
		.cfgCe(cfgCe), .cfgWe(cfgWe), .cfgAddr(cfgAddr), .cfgWdata(cfgWdata),
		.cfgRack(cfgRack), .cfgRdata(cfgRdata),
		.actVld(actVld), .actRdy(actRdy), .actData(actData),
		.resVld(resVld), .resRdy(resRdy), .resData(resData)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	// --------------------
	// Model and monitors
	// --------------------

	// Signed lane products of two words, summed
	function automatic int laneDot(input logic [31:0] w, input logic [31:0] a);
		int sum;
		sum = 0;
		for (int i = 0; i < `WS_LANES; i++)
			sum += int'($signed(w[i*`WS_LANE_BITS +: `WS_LANE_BITS]))
				* int'($signed(a[i*`WS_LANE_BITS +: `WS_LANE_BITS]));
		return sum;
	endfunction

	// Each taken beat pairs the next cyclic shadow word with the activation
	always @(posedge clk) begin
		if (!rst && actVld && actRdy) begin
			groupSum = groupSum + laneDot(shadow[beatCount % DEPTH], actData);
			beatCount = beatCount + 1;
			if (beatCount % FOLD == 0) begin
				expQ.push_back(weightStreamPkg::acc_t'(groupSum));
				groupSum = 0;
			end
		end
	end

	// Results in order against the model queue
	always @(posedge clk) begin
		if (!rst && resVld && resRdy) begin
			checks++;
			assert (expQ.size() > 0) else begin
				$display("Result at %0t arrived with no finished group pending", $time);
				errors++;
			end
			if (expQ.size() > 0) begin
				assert (resData == expQ[0]) else begin
					$display("MISMATCH at %0t: result %0d got %0h expected %0h",
						$time, resultsSeen, resData, expQ[0]);
					errors++;
				end
				void'(expQ.pop_front());
			end
			resultsSeen++;
		end else if (!rst && resVld && !resRdy) begin
			// A waiting result blocks the activation stream
			checks++;
			assert (!actRdy) else begin
				$display("MISMATCH at %0t: actRdy high while a result waits", $time);
				errors++;
			end
		end
	end

	// --------------------
	// Stimulus
	// --------------------

	// Activation source holds each word until taken
	always @(posedge clk) begin
		if (rst) begin
			actVld <= 1'b0;
		end else if (!actVld || actRdy) begin
			if (actSent < actRequested && ($urandom % 100) >= gapPct) begin
				actVld <= 1'b1;
				actData <= $urandom;
				actSent <= actSent + 1;
			end else begin
				actVld <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (rdyMode == 0)
			resRdy <= 1'b1;
		else if (rdyMode == 1)
			resRdy <= (($urandom % 100) >= 40);
		else
			resRdy <= 1'b0;
	end

	task automatic reportTimeout(input string why);
		$display("Timeout at %0t: %s", $time, why);
		timedOut = 1'b1;
	endtask

	task automatic waitResults(input int target);
		int n;
		n = 0;
		while (!timedOut && resultsSeen < target && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!timedOut && resultsSeen < target)
			reportTimeout("expected results did not arrive");
	endtask

	// Until a result sits unread and the stream is frozen
	task automatic waitStall();
		int n;
		n = 0;
		while (!timedOut && !(resVld && !resRdy) && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!timedOut && !(resVld && !resRdy))
			reportTimeout("result output never stalled");
	endtask

	task automatic hostWrite(input int addr, input logic [31:0] data);
		@(posedge clk);
		cfgCe <= 1'b1;
		cfgWe <= 1'b1;
		cfgAddr <= addr;
		cfgWdata <= data;
		shadow[addr] = data;
		@(posedge clk);
		cfgCe <= 1'b0;
	endtask

	// Read-back that counts cycles to rack and checks the word
	task automatic hostRead(input int addr);
		int n;
		@(posedge clk);
		cfgCe <= 1'b1;
		cfgWe <= 1'b0;
		cfgAddr <= addr;
		@(posedge clk);
		cfgCe <= 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!cfgRack && n < TIMEOUT);
		if (!cfgRack) begin
			reportTimeout("read-back acknowledge never came");
		end else begin
			checks++;
			assert (n == 2) else begin
				$display("MISMATCH at %0t: rack after %0d cycles, expected 2", $time, n);
				errors++;
			end
			assert (cfgRdata == shadow[addr]) else begin
				$display("MISMATCH at %0t: addr %0d read %0h expected %0h",
					$time, addr, cfgRdata, shadow[addr]);
				errors++;
			end
		end
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		$display("Test %0d %s: %s", num, name, (errors == errBefore) ? "ok" : "errors");
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		int errBefore;
		int addr;
		int target;
		void'($urandom(34));
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// Nothing may come out with no input
		errBefore = errors;
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			checks++;
			assert (!resVld && !cfgRack) else begin
				$display("MISMATCH at %0t: resVld %b cfgRack %b with no input",
					$time, resVld, cfgRack);
				errors++;
			end
		end
		reportTest(1, "idle after reset", errBefore);

		errBefore = errors;
		for (int i = 0; i < DEPTH; i++)
			hostWrite(i, $urandom);
		for (int i = 0; i < DEPTH; i++)
			hostRead(i);
		reportTest(2, "host write and read-back", errBefore);

		// Three gapless passes over the memory
		errBefore = errors;
		@(posedge clk);
		actRequested <= actRequested + 3 * DEPTH;
		waitResults(3 * DEPTH / FOLD);
		reportTest(3, "full-rate stream", errBefore);

		errBefore = errors;
		@(posedge clk);
		gapPct <= 30;
		rdyMode <= 1;
		actRequested <= actRequested + 3 * DEPTH;
		waitResults(resultsSeen + 3 * DEPTH / FOLD);
		reportTest(4, "random gaps and back-pressure", errBefore);

		// Host traffic against a frozen stream forces rollbacks
		errBefore = errors;
		for (int r = 0; r < 4; r++) begin
			@(posedge clk);
			gapPct <= 0;
			rdyMode <= 2;
			actRequested <= actRequested + 2 * FOLD;
			target = resultsSeen + 2;
			waitStall();
			for (int k = 0; k < 6; k++) begin
				addr = (beatCount + 4 + $urandom % (DEPTH - 4)) % DEPTH;
				if ($urandom % 2)
					hostWrite(addr, $urandom);
				else
					hostRead(addr);
			end
			@(posedge clk);
			rdyMode <= 0;
			waitResults(target);
		end
		reportTest(5, "host access during stall", errBefore);

		checks++;
		assert (expQ.size() == 0) else begin
			$display("%0d finished groups never produced a result", expQ.size());
			errors++;
		end
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
			weightStreamTop_inst.memStream_inst.memStreamAsserts_inst.failCount);
		if (errors == 0 && !timedOut
				&& weightStreamTop_inst.memStream_inst.memStreamAsserts_inst.failCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- sim/weightStream_asserts.sv
// Bound into every memStream; all checks but the reset one are off while rst is high
`timescale 1ns/100ps
`include "weightStream_consts.svh"

module memStreamAsserts (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic we,
	input logic rack,
	input logic wVld,
	input logic wRdy,
	input logic [`WS_WIDTH-1:0] wData
);

	// Failure count, read by the testbench at the end
	int unsigned failCount = 0;

	// --------------------
	// Host port timing
	// --------------------

	// Read-back answer two cycles after the request, never otherwise
	rackTiming: assert property (@(posedge clk) disable iff (rst)
		rack == $past(ce && !we, 2))
	else begin
		$error("rack not exactly two cycles after a read request");
		failCount++;
	end

	// Shared output register, one owner per cycle
	rackOrStream: assert property (@(posedge clk) disable iff (rst) !(rack && wVld))
	else begin
		$error("rack and wVld high in the same cycle");
		failCount++;
	end

	// --------------------
	// Stream timing
	// --------------------

	// Blocked word holds, or is withdrawn by a rollback
	holdWhileBlocked: assert property (@(posedge clk) disable iff (rst)
		(wVld && !wRdy) |=> (!wVld || $stable(wData)))
	else begin
		$error("wData changed while blocked");
		failCount++;
	end

	// Pipeline still empty right after reset
	quietAfterReset: assert property (@(posedge clk) ($past(rst) && !rst) |-> !wVld)
	else begin
		$error("wVld high in the first cycle after reset");
		failCount++;
	end

endmodule

bind memStream memStreamAsserts memStreamAsserts_inst (
	.clk   (clk),
	.rst   (rst),
	.ce    (cfg.ce),
	.we    (cfg.we),
	.rack  (cfg.rack),
	.wVld  (wVld),
	.wRdy  (wRdy),
	.wData (wData)
);

//--- hdl/weightStreamTop.sv
// Host port is plain strobes with no handshake; only the low address bits select a word
`timescale 1ns/100ps
`include "weightStream_consts.svh"

module weightStreamTop (
	input  logic clk,
	input  logic rst,

	// Host port
	input  logic cfgCe,
	input  logic cfgWe,
	input  logic [31:0] cfgAddr,
	input  logic [`WS_WIDTH-1:0] cfgWdata,
	output logic cfgRack,
	output logic [`WS_WIDTH-1:0] cfgRdata,

	// Activation input stream
	input  logic actVld,
	output logic actRdy,
	input  logic [`WS_WIDTH-1:0] actData,

	// Result output stream
	output logic resVld,
	input  logic resRdy,
	output logic [`WS_ACC_BITS-1:0] resData
);

	// --------------------
	// Host port bundle
	// --------------------

	cfgIf cfgBus ();

	assign cfgBus.ce = cfgCe;
	assign cfgBus.we = cfgWe;
	assign cfgBus.addr = cfgAddr;
	assign cfgBus.wdata.raw = cfgWdata;
	assign cfgRack = cfgBus.rack;
	assign cfgRdata = cfgBus.rdata.raw;

	// Weight stream between memory and MAC
	logic wVld;
	logic wRdy;
	weightStreamPkg::weightWord_u wData;

	// Activation pins seen as lanes
	weightStreamPkg::weightWord_u actWord;
	assign actWord.raw = actData;

	// --------------------
	// Blocks
	// --------------------

	memStream memStream_inst (
		.clk   (clk),
		.rst   (rst),
		.cfg   (cfgBus.mem),
		.wRdy  (wRdy),
		.wVld  (wVld),
		.wData (wData)
	);

	dotAccumulator dotAccumulator_inst (
		.clk     (clk),
		.rst     (rst),
		.wVld    (wVld),
		.wRdy    (wRdy),
		.wData   (wData),
		.actVld  (actVld),
		.actRdy  (actRdy),
		.actData (actWord),
		.resVld  (resVld),
		.resRdy  (resRdy),
		.resData (resData)
	);

endmodule

//--- hdl/dotAccumulator.sv
// No saturation; the sum wraps at WS_ACC_BITS and both inputs advance only together
`timescale 1ns/100ps
`include "weightStream_consts.svh"

module dotAccumulator (
	input  logic clk,
	input  logic rst,
	input  logic wVld,
	output logic wRdy,
	input  weightStreamPkg::weightWord_u wData,
	input  logic actVld,
	output logic actRdy,
	input  weightStreamPkg::weightWord_u actData,
	output logic resVld,
	input  logic resRdy,
	output weightStreamPkg::acc_t resData
);

	localparam int unsigned FOLD = `WS_FOLD;
	localparam int unsigned CNT_BITS = ($clog2(FOLD) > 0) ? $clog2(FOLD) : 1;

	// Free unless a result sits unread
	logic ready;
	// Both words taken this cycle
	logic beat;
	// Final beat of a group
	logic lastBeat;

	// Beats seen in the current group
	logic [CNT_BITS-1:0] beatCnt;
	// Partial sum of the group
	weightStreamPkg::acc_t acc;
	// Four lane products added up
	weightStreamPkg::acc_t beatSum;
	weightStreamPkg::acc_t accNext;

	// --------------------
	// Handshake
	// --------------------

	assign ready = !(resVld && !resRdy);
	// Each side waits for the other stream
	assign wRdy = actVld && ready;
	assign actRdy = wVld && ready;
	assign beat = wVld && actVld && ready;
	assign lastBeat = (beatCnt == CNT_BITS'(FOLD - 1));

	// --------------------
	// Lane products
	// --------------------

	// Sign-extend lanes before multiplying
	always_comb begin
		beatSum = '0;
		for (int i = 0; i < `WS_LANES; i++) begin
			beatSum = beatSum
				+ weightStreamPkg::acc_t'(wData.lanes[i])
				* weightStreamPkg::acc_t'(actData.lanes[i]);
		end
	end

	assign accNext = acc + beatSum;

	// --------------------
	// Fold and result
	// --------------------

	// Group counter and running sum
	always_ff @(posedge clk) begin
		if (rst) begin
			beatCnt <= '0;
			acc <= '0;
		end else if (beat) begin
			if (lastBeat) begin
				beatCnt <= '0;
				// Start the next group from zero
				acc <= '0;
			end else begin
				beatCnt <= beatCnt + 1'b1;
				acc <= accNext;
			end
		end
	end

	// Result valid one cycle after the last beat, held until taken
	always_ff @(posedge clk) begin
		if (rst)
			resVld <= 1'b0;
		else if (beat && lastBeat)
			resVld <= 1'b1;
		else if (resRdy)
			resVld <= 1'b0;
	end

	// Full group sum
	always_ff @(posedge clk) begin
		if (beat && lastBeat)
			resData <= accNext;
	end

endmodule

//--- hdl/memStream.sv
// Host access always wins over the stream; a blocked stream read is dropped and reissued
`timescale 1ns/100ps
`include "weightStream_consts.svh"

module memStream (
	input  logic clk,
	input  logic rst,
	cfgIf.mem cfg,
	input  logic wRdy,
	output logic wVld,
	output weightStreamPkg::weightWord_u wData
);

	localparam int unsigned DEPTH = `WS_DEPTH;
	localparam int unsigned AW = `WS_ADDR_BITS;

	// Pipeline advance
	logic en;
	// Output blocked by the consumer
	logic backpressure;
	// Host access forces the pipe forward, stream read gets undone
	logic rollback;

	// Pointer history
	// 0 is the next stream address, 1 and 2 follow the two stages
	logic [AW-1:0] ptr0Val;
	logic ptr0Lst;
	logic [AW-1:0] ptr1Val;
	logic ptr1Lst;
	logic [AW-1:0] ptr2Val;
	logic ptr2Lst;

	// Pointer that the next stream read is based on
	logic [AW-1:0] ptrEffVal;
	logic ptrEffLst;
	logic [AW-1:0] ptrNxtVal;
	logic ptrNxtLst;

	// Stage one op flags and write data
	logic wr1;
	logic rb1;
	logic rs1;
	logic [`WS_WIDTH-1:0] data1;

	// Stage two designation and read data
	logic rb2;
	logic rs2;
	weightStreamPkg::weightWord_u rdOut;

	// Weight storage
	logic [`WS_WIDTH-1:0] mem [DEPTH];

	// --------------------
	// Stream pointer
	// --------------------

	// After a rollback, restart from the word that was blocked at the output
	assign ptrEffVal = rollback ? ptr2Val : ptr0Val;
	assign ptrEffLst = rollback ? ptr2Lst : ptr0Lst;

	// Counter with last flag computed a cycle ahead
	always_comb begin
		if (cfg.ce) begin
			// Host takes the slot, no advance
			ptrNxtVal = ptrEffVal;
			ptrNxtLst = ptrEffLst;
		end else if (ptrEffLst) begin
			// Wrap to address 0
			ptrNxtVal = '0;
			ptrNxtLst = (DEPTH < 2);
		end else begin
			ptrNxtVal = ptrEffVal + 1'b1;
			ptrNxtLst = (ptrEffVal == AW'(DEPTH - 2));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr0Val <= '0;
			ptr0Lst <= (DEPTH < 2);
		end else if (en) begin
			ptr0Val <= ptrNxtVal;
			ptr0Lst <= ptrNxtLst;
		end
	end

	// --------------------
	// Stage one, op select
	// --------------------

	// Host first, stream read in every free cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			wr1 <= 1'b0;
			rb1 <= 1'b0;
			rs1 <= 1'b0;
		end else if (en) begin
			wr1 <= cfg.ce && cfg.we;
			rb1 <= cfg.ce && !cfg.we;
			rs1 <= !cfg.ce;
		end
	end

	// Address and write word for the memory stage
	always_ff @(posedge clk) begin
		if (en) begin
			data1 <= cfg.wdata.raw;
			if (cfg.ce) begin
				ptr1Val <= cfg.addr[AW-1:0];
				// Host addresses never feed the counter back
				ptr1Lst <= 1'b0;
			end else begin
				ptr1Val <= ptrEffVal;
				ptr1Lst <= ptrEffLst;
			end
		end
	end

	// --------------------
	// Stage two, memory
	// --------------------

	// Read and write never in the same cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (wr1)
				mem[ptr1Val] <= data1;
			else
				rdOut.raw <= mem[ptr1Val];
		end
	end

	// Mark what the read data is for
	always_ff @(posedge clk) begin
		if (rst) begin
			rb2 <= 1'b0;
			rs2 <= 1'b0;
		end else if (en) begin
			rb2 <= rb1;
			// Stream read is discarded when rolled back
			rs2 <= rs1 && !rollback;
		end
	end

	// Address of the word now at the output, needed for rollback
	always_ff @(posedge clk) begin
		if (en) begin
			ptr2Val <= ptr1Val;
			ptr2Lst <= ptr1Lst;
		end
	end

	// --------------------
	// Outputs and control
	// --------------------

	assign cfg.rack = rb2;
	assign cfg.rdata = rdOut;

	assign wVld = rs2;
	assign wData = rdOut;

	assign backpressure = rs2 && !wRdy;
	// Pending host op in either stage overrides the stall
	assign rollback = backpressure && (rb1 || cfg.ce);
	assign en = !backpressure || rb1 || cfg.ce;

endmodule

//--- hdl/cfgIf.sv
// Host port has no handshake; ce is always taken and rack answers a read two cycles later
`timescale 1ns/100ps

interface cfgIf;

	// Request side
	// One-cycle strobe, write when we is high, read-back otherwise
	logic ce;
	logic we;
	// Byte-free word address, only the low bits reach the memory
	logic [31:0] addr;
	weightStreamPkg::weightWord_u wdata;

	// Response side
	// Single-cycle pulse, rdata valid with it
	logic rack;
	weightStreamPkg::weightWord_u rdata;

	// Driving side, the host or the top-level pins
	modport host (
		output ce,
		output we,
		output addr,
		output wdata,
		input  rack,
		input  rdata
	);

	// Memory side
	modport mem (
		input  ce,
		input  we,
		input  addr,
		input  wdata,
		output rack,
		output rdata
	);

endinterface

//--- hdl/weightStreamPkg.sv
// Types only; widths follow the header, lane 0 sits in the low byte of a word
`include "weightStream_consts.svh"

package weightStreamPkg;

	// --------------------
	// Lane and word types
	// --------------------

	// One signed lane value
	typedef logic signed [`WS_LANE_BITS-1:0] lane_t;

	// Same 32 bits, seen as raw data or as lanes
	// Raw view for host port and memory, lanes view for the MAC
	typedef union packed {
		logic [`WS_WIDTH-1:0] raw;
		lane_t [`WS_LANES-1:0] lanes;
	} weightWord_u;

	// --------------------
	// Accumulation
	// --------------------

	// Running sum and result, wide enough for WS_FOLD beats of four products
	typedef logic signed [`WS_ACC_BITS-1:0] acc_t;

endpackage

//--- hdl/weightStream_consts.svh
// Sizes are fixed here; WS_DEPTH must be a multiple of WS_FOLD and fit in WS_ADDR_BITS
`ifndef WEIGHTSTREAM_CONSTS_SVH
`define WEIGHTSTREAM_CONSTS_SVH

// Weight memory geometry
`define WS_WIDTH      32
`define WS_DEPTH      16
`define WS_ADDR_BITS  4

// Lane split of one word
`define WS_LANES      4
`define WS_LANE_BITS  8

// Beats summed per result, accumulator width
`define WS_FOLD       4
`define WS_ACC_BITS   20

`endif
